//--- src/beat_packer.sv
/*
 * Spreads read beats over the lanes of one register word.
 * Beats are full and aligned, one 64-bit element each. Element n goes to
 * lane n mod NrLanes of word n / NrLanes. A finished word is pushed in the
 * cycle of its last beat, or held while the result queue is full, and the
 * read channel stalls as long as it is held.
 */
`timescale 1ns/1ns

module beat_packer import vldu_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Memory read channel
  input  axi_r_t                     r_i,
  input  logic                       r_valid_i,
  output logic                       r_ready_o,
  // Instruction being issued
  input  pe_req_t                    issue_req_i,
  input  logic                       issue_valid_i,
  output logic                       issue_done_o,
  // Result queue side
  output logic                       push_o,
  output lane_result_t [NrLanes-1:0] push_word_o,
  input  logic                       full_i
);

  // Progress within the current instruction
  vl_t       elem_cnt_q, elem_cnt_d;
  lane_idx_t lane_q, lane_d;
  logic      pending_q, pending_d;

  // Assembly register
  elen_t [NrLanes-1:0] data_q, data_d;
  strb_t [NrLanes-1:0] be_q, be_d;
  vid_t                id_q, id_d;
  vaddr_t              addr_q, addr_d;

  logic   beat_fire;
  logic   last_elem;
  logic   word_done;
  vaddr_t word_addr;

  // No new beat while a finished word waits for space
  assign r_ready_o = issue_valid_i && !pending_q;
  assign beat_fire = r_valid_i && r_ready_o;

  assign last_elem    = (elem_cnt_q == issue_req_i.vl - vl_t'(1));
  assign issue_done_o = beat_fire && last_elem;
  // Word closes when the lane pointer wraps or the instruction ends
  assign word_done    = beat_fire && (last_elem || (lane_q == lane_idx_t'(NrLanes - 1)));

  // vd * VRegWords + word index, VRegWords being the range of word_idx_t
  assign word_addr = {issue_req_i.vd, word_idx_t'(elem_cnt_q >> LaneIdxW)};

  always_comb begin
    data_d     = data_q;
    be_d       = be_q;
    id_d       = id_q;
    addr_d     = addr_q;
    elem_cnt_d = elem_cnt_q;
    lane_d     = lane_q;
    if (beat_fire) begin
      data_d[lane_q] = r_i.data;
      be_d[lane_q]   = '1;
      id_d           = issue_req_i.id;
      addr_d         = word_addr;
      elem_cnt_d     = last_elem ? '0 : elem_cnt_q + vl_t'(1);
      lane_d         = last_elem ? '0 : lane_q + 1'b1;
    end
    // Hand over now if the queue has room, else keep it
    push_o    = (word_done || pending_q) && !full_i;
    pending_d = (word_done || pending_q) && full_i;
    for (int l = 0; l < NrLanes; l++) begin
      push_word_o[l] = '{id: id_d, addr: addr_d, wdata: data_d[l], be: be_d[l]};
    end
    // Unfilled lanes of the next word get zero enables
    if (push_o) begin
      be_d = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    data_q <= data_d;
    id_q   <= id_d;
    addr_q <= addr_d;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      elem_cnt_q <= '0;
      lane_q     <= '0;
      pending_q  <= 1'b0;
      be_q       <= '0;
    end else begin
      elem_cnt_q <= elem_cnt_d;
      lane_q     <= lane_d;
      pending_q  <= pending_d;
      be_q       <= be_d;
    end
  end

endmodule

//--- src/result_queue.sv
/*
 * Two-entry queue of register words, one valid bit per lane and entry.
 * Every lane of the head word is requested, also those with zero enables.
 * Lanes are granted independently and the head pops in the cycle its last
 * outstanding lane is granted. A push is taken only while full_o is low.
 */
`timescale 1ns/1ns

module result_queue import vldu_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // From the beat packer
  input  logic                       push_i,
  input  lane_result_t [NrLanes-1:0] push_word_i,
  output logic                       full_o,
  // Lane write ports
  output logic         [NrLanes-1:0] ldu_result_req_o,
  output lane_result_t [NrLanes-1:0] ldu_result_o,
  input  logic         [NrLanes-1:0] ldu_result_gnt_i,
  // Head entry retired
  output logic                       pop_o
);

  // Word storage and per-lane pending requests
  lane_result_t [ResultQueueDepth-1:0][NrLanes-1:0] mem_q;
  logic [ResultQueueDepth-1:0][NrLanes-1:0] valid_q, valid_d;

  rq_ptr_t wr_pnt_q, rd_pnt_q;
  rq_cnt_t cnt_q;
  logic    push_fire;

  assign full_o    = (cnt_q == rq_cnt_t'(ResultQueueDepth));
  assign push_fire = push_i && !full_o;

  // Head entry drives all lanes
  assign ldu_result_req_o = valid_q[rd_pnt_q];
  assign ldu_result_o     = mem_q[rd_pnt_q];

  always_comb begin
    valid_d = valid_q;
    // A grant retires that lane's request
    for (int l = 0; l < NrLanes; l++) begin
      if (valid_q[rd_pnt_q][l] && ldu_result_gnt_i[l]) begin
        valid_d[rd_pnt_q][l] = 1'b0;
      end
    end
    // Pop once nothing is left in the head
    pop_o = (cnt_q != '0) && (valid_d[rd_pnt_q] == '0);
    // New word requests every lane
    if (push_fire) begin
      valid_d[wr_pnt_q] = '1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_fire) begin
      mem_q[wr_pnt_q] <= push_word_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      valid_q <= valid_d;
      if (push_fire) begin
        wr_pnt_q <= wr_pnt_q + 1'b1;
      end
      if (pop_o) begin
        rd_pnt_q <= rd_pnt_q + 1'b1;
      end
      cnt_q <= cnt_q + rq_cnt_t'(push_fire) - rq_cnt_t'(pop_o);
    end
  end

endmodule

//--- src/vinsn_queue.sv
/*
 * Four-entry instruction queue with separate accept, issue and commit phases.
 * Requests for other units or with a still running ID are dropped silently,
 * even while ready is high. The words of the instruction at commit are
 * counted by result queue pops, and its done bit pulses one cycle after
 * the last pop.
 */
`timescale 1ns/1ns

module vinsn_queue import vldu_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Sequencer side
  input  pe_req_t            pe_req_i,
  input  logic               pe_req_valid_i,
  output logic               pe_req_ready_o,
  input  logic [NrVInsn-1:0] vinsn_running_i,
  // Issue phase towards the beat packer
  output pe_req_t            issue_req_o,
  output logic               issue_valid_o,
  input  logic               issue_done_i,
  // Commit phase from the result queue
  input  logic               pop_i,
  output logic               load_complete_o,
  output logic [NrVInsn-1:0] vinsn_done_o
);

  // Instruction storage
  pe_req_t [VInsnQueueDepth-1:0] vinsn_q;

  // Phase pointers and occupancy
  vq_ptr_t accept_pnt_q, issue_pnt_q, commit_pnt_q;
  vq_cnt_t issue_cnt_q, commit_cnt_q;

  // IDs in flight in this unit
  logic [NrVInsn-1:0] running_q, running_d;
  logic [NrVInsn-1:0] done_d;

  // Words already popped for the instruction at commit
  word_idx_t commit_word_q;
  word_idx_t last_word;

  pe_req_t commit_insn;
  logic    full;
  logic    accept;

  ////////////////////////////////////////////////////////////////////////////
  // Accept
  ////////////////////////////////////////////////////////////////////////////

  assign full           = (commit_cnt_q == vq_cnt_t'(VInsnQueueDepth));
  assign pe_req_ready_o = !full;

  // Only loads with an idle ID enter the queue
  assign accept = pe_req_valid_i && !full && (pe_req_i.vfu == VFU_LoadUnit) &&
                  !running_q[pe_req_i.id];

  // Issue side sees the oldest instruction not yet fully received
  assign issue_req_o   = vinsn_q[issue_pnt_q];
  assign issue_valid_o = (issue_cnt_q != '0);

  ////////////////////////////////////////////////////////////////////////////
  // Commit
  ////////////////////////////////////////////////////////////////////////////

  assign commit_insn = vinsn_q[commit_pnt_q];
  // Index of the final word, four elements per word
  assign last_word   = word_idx_t'((commit_insn.vl - vl_t'(1)) >> LaneIdxW);

  // Last word of the committing instruction leaves the result queue
  assign load_complete_o = pop_i && (commit_cnt_q != '0) && (commit_word_q == last_word);

  always_comb begin
    // Sequencer clears bits of retired IDs
    running_d = running_q & vinsn_running_i;
    if (accept) begin
      running_d[pe_req_i.id] = 1'b1;
    end
    done_d = '0;
    if (load_complete_o) begin
      done_d[commit_insn.id] = 1'b1;
    end
  end

  // Entries carry no reset
  always_ff @(posedge clk_i) begin
    if (accept) begin
      vinsn_q[accept_pnt_q] <= pe_req_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q  <= '0;
      issue_pnt_q   <= '0;
      commit_pnt_q  <= '0;
      issue_cnt_q   <= '0;
      commit_cnt_q  <= '0;
      commit_word_q <= '0;
      running_q     <= '0;
      vinsn_done_o  <= '0;
    end else begin
      running_q    <= running_d;
      vinsn_done_o <= done_d;
      if (accept) begin
        accept_pnt_q <= accept_pnt_q + 1'b1;
      end
      if (issue_done_i) begin
        issue_pnt_q <= issue_pnt_q + 1'b1;
      end
      // Occupancy follows accept, issue and commit events of this cycle
      issue_cnt_q  <= issue_cnt_q + vq_cnt_t'(accept) - vq_cnt_t'(issue_done_i);
      commit_cnt_q <= commit_cnt_q + vq_cnt_t'(accept) - vq_cnt_t'(load_complete_o);
      if (load_complete_o) begin
        commit_pnt_q  <= commit_pnt_q + 1'b1;
        commit_word_q <= '0;
      end else if (pop_i) begin
        commit_word_q <= commit_word_q + 1'b1;
      end
    end
  end

endmodule

//--- src/vldu_pkg.sv
/*
 * Shared sizes and types of the vector load unit.
 * Elements and lane words are both 64 bits, so one read beat is one element.
 * VInsnQueueDepth, ResultQueueDepth and NrLanes must be powers of two,
 * because the pointers wrap by overflow.
 */
package vldu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned NrLanes          = 4;
  localparam int unsigned ElenBytes        = 8;
  localparam int unsigned NrVInsn          = 8;
  localparam int unsigned VInsnQueueDepth  = 4;
  localparam int unsigned ResultQueueDepth = 2;
  // Lane words per vector register, 32 elements at most per instruction
  localparam int unsigned VRegWords        = 8;

  // Derived pointer widths
  localparam int unsigned LaneIdxW = $clog2(NrLanes);
  localparam int unsigned VqPtrW   = $clog2(VInsnQueueDepth);
  localparam int unsigned RqPtrW   = $clog2(ResultQueueDepth);

  ////////////////////////////////////////////////////////////////////////////
  // Scalar types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [2:0]               vid_t;
  typedef logic [4:0]               vreg_t;
  // Element count, legal range 1 to 32
  typedef logic [5:0]               vl_t;
  // Register number times VRegWords plus word index
  typedef logic [7:0]               vaddr_t;
  typedef logic [8*ElenBytes-1:0]   elen_t;
  typedef logic [ElenBytes-1:0]     strb_t;
  typedef logic [$clog2(VRegWords)-1:0] word_idx_t;
  typedef logic [LaneIdxW-1:0]      lane_idx_t;
  typedef logic [VqPtrW-1:0]        vq_ptr_t;
  typedef logic [VqPtrW:0]          vq_cnt_t;
  typedef logic [RqPtrW-1:0]        rq_ptr_t;
  typedef logic [RqPtrW:0]          rq_cnt_t;

  typedef enum logic [1:0] {
    VFU_Alu,
    VFU_LoadUnit,
    VFU_StoreUnit
  } vfu_e;

  ////////////////////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////////////////////

  // Instruction from the sequencer, 16 bits
  typedef struct packed {
    vid_t  id;
    vfu_e  vfu;
    vreg_t vd;
    vl_t   vl;
  } pe_req_t;

  // Read beat, last is informational only
  typedef struct packed {
    elen_t data;
    logic  last;
  } axi_r_t;

  // One lane's register file write, 83 bits
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } lane_result_t;

endpackage

//--- src/vldu_top.sv
/*
 * Vector load unit top level.
 * Chain of instruction queue, beat packer and result queue. Back-pressure
 * runs from the lane grants through the result queue to r_ready_o.
 */
`timescale 1ns/1ns

module vldu_top import vldu_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Sequencer
  input  pe_req_t                    pe_req_i,
  input  logic                       pe_req_valid_i,
  output logic                       pe_req_ready_o,
  input  logic         [NrVInsn-1:0] vinsn_running_i,
  output logic         [NrVInsn-1:0] vinsn_done_o,
  output logic                       load_complete_o,
  // Memory read channel
  input  axi_r_t                     r_i,
  input  logic                       r_valid_i,
  output logic                       r_ready_o,
  // Lanes
  output logic         [NrLanes-1:0] ldu_result_req_o,
  output lane_result_t [NrLanes-1:0] ldu_result_o,
  input  logic         [NrLanes-1:0] ldu_result_gnt_i
);

  // Issue phase
  pe_req_t issue_req;
  logic    issue_valid;
  logic    issue_done;

  // Word hand-over and commit feedback
  logic                       push;
  lane_result_t [NrLanes-1:0] push_word;
  logic                       rq_full;
  logic                       pop;

  vinsn_queue i_vinsn_queue (
    .clk_i, .rst_ni, .pe_req_i, .pe_req_valid_i, .pe_req_ready_o, .vinsn_running_i,
    .issue_req_o (issue_req), .issue_valid_o (issue_valid), .issue_done_i (issue_done),
    .pop_i (pop), .load_complete_o, .vinsn_done_o
  );

  beat_packer i_beat_packer (
    .clk_i, .rst_ni, .r_i, .r_valid_i, .r_ready_o,
    .issue_req_i (issue_req), .issue_valid_i (issue_valid), .issue_done_o (issue_done),
    .push_o (push), .push_word_o (push_word), .full_i (rq_full)
  );

  result_queue i_result_queue (
    .clk_i, .rst_ni, .push_i (push), .push_word_i (push_word), .full_o (rq_full),
    .ldu_result_req_o, .ldu_result_o, .ldu_result_gnt_i, .pop_o (pop)
  );

endmodule

//--- tb/tb_vldu.sv
/*
 * Directed testbench of the vector load unit.
 * Inputs change on the falling edge. A lane write is taken at the falling
 * edge where its request is seen and its grant is driven. Completions are
 * sampled in the middle of the low phase.
 * Lanes with zero enables are checked for ID, address and enables only.
 */
`timescale 1ns/1ns

module tb_vldu import vldu_pkg::*; ();

  localparam int unsigned HalfPeriod     = 20;
  localparam int unsigned ResetCycles    = 16;
  // Six tests of at most a few hundred cycles each, with wide margin
  localparam int unsigned WatchdogCycles = 4000;
  localparam logic [31:0] RandSeed       = 32'h148c_0851;

  logic                       clk_i;
  logic                       rst_ni;
  pe_req_t                    pe_req;
  logic                       pe_req_valid;
  logic                       pe_req_ready;
  logic         [NrVInsn-1:0] vinsn_running;
  logic         [NrVInsn-1:0] vinsn_done;
  logic                       load_complete;
  axi_r_t                     r_beat;
  logic                       r_valid;
  logic                       r_ready;
  logic         [NrLanes-1:0] lane_req;
  logic         [NrLanes-1:0] lane_gnt;
  lane_result_t [NrLanes-1:0] lane_result;

  // Expected lane writes in arrival order, IDs in commit order
  lane_result_t       exp_lane_q [NrLanes][$];
  vid_t               exp_done_q [$];
  logic [NrVInsn-1:0] done_due;
  logic [NrVInsn-1:0] running_clear;
  logic               grant_random;
  int unsigned        completed;
  int unsigned        stall_cycles;

  vldu_top i_dut (
    .clk_i, .rst_ni,
    .pe_req_i (pe_req), .pe_req_valid_i (pe_req_valid), .pe_req_ready_o (pe_req_ready),
    .vinsn_running_i (vinsn_running), .vinsn_done_o (vinsn_done),
    .load_complete_o (load_complete),
    .r_i (r_beat), .r_valid_i (r_valid), .r_ready_o (r_ready),
    .ldu_result_req_o (lane_req), .ldu_result_o (lane_result), .ldu_result_gnt_i (lane_gnt)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Clock and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #HalfPeriod clk_i = ~clk_i;
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("Timeout, the tests did not finish within %0d clock periods", WatchdogCycles);
    stop_on_failure();
  end

  task automatic stop_on_failure();
    $display("Verification failed");
    $fatal(1, "Run stopped at the first failure");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_result(string name, lane_result_t got, lane_result_t exp);
    elen_t mask;
    // Data counts only in enabled bytes
    for (int b = 0; b < ElenBytes; b++) begin
      mask[8*b +: 8] = {8{exp.be[b]}};
    end
    if (got.id !== exp.id || got.addr !== exp.addr || got.be !== exp.be ||
        (got.wdata & mask) !== (exp.wdata & mask)) begin
      $display("error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_done(string name, logic [NrVInsn-1:0] got, logic [NrVInsn-1:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
      stop_on_failure();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and expected values
  ////////////////////////////////////////////////////////////////////////////

  // Element n of instruction id
  function automatic elen_t elem_value(vid_t id, int unsigned n);
    return {8'hd0, 5'd0, id, 16'h1234, 8'(n), 24'h5a_c3e1};
  endfunction

  // Element n lands in lane n mod 4 of word n / 4, at vd * 8 + word
  task automatic expect_insn(pe_req_t req);
    lane_result_t res;
    int unsigned  n;
    for (int unsigned w = 0; w < (req.vl + NrLanes - 1) / NrLanes; w++) begin
      for (int unsigned l = 0; l < NrLanes; l++) begin
        n         = w * NrLanes + l;
        res.id    = req.id;
        res.addr  = vaddr_t'(req.vd * VRegWords + w);
        res.wdata = (n < req.vl) ? elem_value(req.id, n) : '0;
        res.be    = (n < req.vl) ? '1 : '0;
        exp_lane_q[l].push_back(res);
      end
    end
    exp_done_q.push_back(req.id);
  endtask

  // Offers a load until the queue can take it
  task automatic send_insn(pe_req_t req);
    @(negedge clk_i);
    pe_req                = req;
    pe_req_valid          = 1'b1;
    vinsn_running[req.id] = 1'b1;
    while (!pe_req_ready) begin
      @(negedge clk_i);
    end
    expect_insn(req);
    @(negedge clk_i);
    pe_req_valid = 1'b0;
  endtask

  // One cycle offer of a request that the DUT must drop
  task automatic offer_ignored(pe_req_t req);
    @(negedge clk_i);
    check_bit("pe_req_ready_o", pe_req_ready, 1'b1);
    pe_req       = req;
    pe_req_valid = 1'b1;
    @(negedge clk_i);
    pe_req_valid = 1'b0;
  endtask

  task automatic send_beats(vid_t id, int unsigned vl);
    for (int unsigned n = 0; n < vl; n++) begin
      @(negedge clk_i);
      r_valid = 1'b1;
      r_beat  = '{data: elem_value(id, n), last: (n == vl - 1)};
      // Beat moves at the next rising edge once ready is seen here
      while (!r_ready) begin
        stall_cycles++;
        @(negedge clk_i);
      end
    end
    @(negedge clk_i);
    r_valid = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_done_q.size() != 0 || done_due != '0) begin
      @(negedge clk_i);
    end
    repeat (2) @(negedge clk_i);
  endtask

  // Lane model, completion tracking and sequencer running bits
  initial begin
    lane_result_t exp;
    vid_t         id;
    logic         exp_complete;
    void'($urandom(RandSeed));
    forever begin
      @(negedge clk_i);
      vinsn_running = vinsn_running & ~running_clear;
      running_clear = '0;
      for (int l = 0; l < NrLanes; l++) begin
        lane_gnt[l] = grant_random ? ($urandom % 8 == 0) : 1'b1;
        if (lane_req[l] && lane_gnt[l]) begin
          if (exp_lane_q[l].size() == 0) begin
            $display("Lane %0d received a word that no instruction asked for", l);
            stop_on_failure();
          end
          exp = exp_lane_q[l].pop_front();
          check_result($sformatf("ldu_result_o[%0d]", l), lane_result[l], exp);
        end
      end
      #(HalfPeriod / 2);
      if (i_dut.i_vldu_props.fail_cnt != 0) begin
        $display("A bound assertion on the DUT handshakes failed");
        stop_on_failure();
      end
      check_done("vinsn_done_o", vinsn_done, done_due);
      running_clear = done_due;
      done_due      = '0;
      // Oldest load completes with the grant that retires its last word
      exp_complete = 1'b0;
      if (exp_done_q.size() != 0) begin
        exp_complete = 1'b1;
        for (int l = 0; l < NrLanes; l++) begin
          if (exp_lane_q[l].size() != 0) begin
            exp = exp_lane_q[l][0];
            if (exp.id == exp_done_q[0]) begin
              exp_complete = 1'b0;
            end
          end
        end
      end
      check_bit("load_complete_o", load_complete, exp_complete);
      if (load_complete) begin
        id           = exp_done_q.pop_front();
        done_due[id] = 1'b1;
        completed++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset_levels();
    check_bit("r_ready_o", r_ready, 1'b0);
    check_bit("load_complete_o", load_complete, 1'b0);
    check_bit("pe_req_ready_o", pe_req_ready, 1'b1);
    check_done("vinsn_done_o", vinsn_done, '0);
    for (int l = 0; l < NrLanes; l++) begin
      check_bit($sformatf("ldu_result_req_o[%0d]", l), lane_req[l], 1'b0);
    end
  endtask

  // Two full words at addresses 16 and 17
  task automatic test_full_words();
    send_insn('{id: 3'd1, vfu: VFU_LoadUnit, vd: 5'd2, vl: 6'd8});
    send_beats(3'd1, 8);
    wait_drained();
  endtask

  task automatic test_partial_word();
    send_insn('{id: 3'd2, vfu: VFU_LoadUnit, vd: 5'd5, vl: 6'd6});
    send_beats(3'd2, 6);
    wait_drained();
  endtask

  // Slow random grants fill the result queue and stall the read channel
  task automatic test_back_pressure();
    grant_random = 1'b1;
    stall_cycles = 0;
    send_insn('{id: 3'd3, vfu: VFU_LoadUnit, vd: 5'd8, vl: 6'd12});
    send_insn('{id: 3'd4, vfu: VFU_LoadUnit, vd: 5'd12, vl: 6'd5});
    send_beats(3'd3, 12);
    send_beats(3'd4, 5);
    check_bit("r_ready_o", stall_cycles != 0, 1'b1);
    wait_drained();
    grant_random = 1'b0;
  endtask

  task automatic test_queue_limits();
    int unsigned start;
    start = completed;
    send_insn('{id: 3'd5, vfu: VFU_LoadUnit, vd: 5'd16, vl: 6'd4});
    send_insn('{id: 3'd6, vfu: VFU_LoadUnit, vd: 5'd17, vl: 6'd3});
    // ID 6 is still running
    offer_ignored('{id: 3'd6, vfu: VFU_LoadUnit, vd: 5'd20, vl: 6'd8});
    send_insn('{id: 3'd7, vfu: VFU_LoadUnit, vd: 5'd18, vl: 6'd5});
    check_bit("pe_req_ready_o", pe_req_ready, 1'b1);
    send_insn('{id: 3'd0, vfu: VFU_LoadUnit, vd: 5'd19, vl: 6'd2});
    check_bit("pe_req_ready_o", pe_req_ready, 1'b0);
    send_beats(3'd5, 4);
    while (completed == start) begin
      @(negedge clk_i);
    end
    send_insn('{id: 3'd1, vfu: VFU_LoadUnit, vd: 5'd21, vl: 6'd7});
    send_beats(3'd6, 3);
    send_beats(3'd7, 5);
    send_beats(3'd0, 2);
    send_beats(3'd1, 7);
    wait_drained();
  endtask

  // ALU request must leave the read channel closed
  task automatic test_foreign_unit();
    offer_ignored('{id: 3'd2, vfu: VFU_Alu, vd: 5'd3, vl: 6'd4});
    r_valid = 1'b1;
    r_beat  = '{data: elem_value(3'd2, 0), last: 1'b0};
    repeat (8) begin
      @(negedge clk_i);
      check_bit("r_ready_o", r_ready, 1'b0);
    end
    r_valid = 1'b0;
    repeat (2) @(negedge clk_i);
  endtask

  initial begin
    rst_ni        = 1'b0;
    pe_req        = '0;
    pe_req_valid  = 1'b0;
    vinsn_running = '0;
    r_beat        = '0;
    r_valid       = 1'b0;
    lane_gnt      = '0;
    grant_random  = 1'b0;
    done_due      = '0;
    running_clear = '0;
    completed     = 0;
    stall_cycles  = 0;
    repeat (ResetCycles) @(negedge clk_i);
    rst_ni = 1'b1;
    test_reset_levels();
    test_full_words();
    test_partial_word();
    test_back_pressure();
    test_queue_limits();
    test_foreign_unit();
    if (exp_done_q.size() == 0 && exp_lane_q[0].size() == 0 && exp_lane_q[1].size() == 0 &&
        exp_lane_q[2].size() == 0 && exp_lane_q[3].size() == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("Words or completions were still outstanding at the end of the run");
      stop_on_failure();
    end
  end

endmodule

//--- tb/vldu_props.sv
/*
 * Concurrent checks on the load unit handshakes, bound into vldu_top.
 * All checks are off while reset is asserted.
 * Instructions taken are counted from the accept strobe and the done bits.
 * fail_cnt holds the number of failed checks.
 */
`timescale 1ns/1ns

module vldu_props import vldu_pkg::*; (
  input logic               clk_i,
  input logic               rst_ni,
  input logic               accept_i,
  input logic               r_ready_i,
  input logic [NrLanes-1:0] lane_req_i,
  input logic [NrLanes-1:0] lane_gnt_i,
  input logic               load_complete_i,
  input logic [NrVInsn-1:0] vinsn_done_i,
  input logic               pe_req_ready_i
);

  int unsigned fail_cnt = 0;
  // Instructions taken and not yet reported done
  int unsigned taken_cnt;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      taken_cnt <= 0;
    end else begin
      taken_cnt <= taken_cnt + 32'(accept_i) - 32'($countones(vinsn_done_i));
    end
  end

  // Read channel opens only while the unit holds an instruction
  assert property (@(posedge clk_i) disable iff (!rst_ni) $rose(r_ready_i) |-> taken_cnt != 0)
    else begin
      $error("r_ready_o rose with no instruction held");
      fail_cnt++;
    end

  for (genvar l = 0; l < NrLanes; l++) begin : g_lane
    // Request holds until its grant
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      lane_req_i[l] && !lane_gnt_i[l] |=> lane_req_i[l])
      else begin
        $error("lane %0d request dropped without a grant", l);
        fail_cnt++;
      end
  end

  // One done bit follows each completion
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    load_complete_i |=> $onehot(vinsn_done_i))
    else begin
      $error("load_complete_o not followed by exactly one done bit");
      fail_cnt++;
    end

  // Back-pressure to the sequencer only with a full queue
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !pe_req_ready_i |-> taken_cnt == VInsnQueueDepth)
    else begin
      $error("pe_req_ready_o low with fewer than four instructions held");
      fail_cnt++;
    end

endmodule

bind vldu_top vldu_props i_vldu_props (
  .clk_i,
  .rst_ni,
  .accept_i        (i_vinsn_queue.accept),
  .r_ready_i       (r_ready_o),
  .lane_req_i      (ldu_result_req_o),
  .lane_gnt_i      (ldu_result_gnt_i),
  .load_complete_i (load_complete_o),
  .vinsn_done_i    (vinsn_done_o),
  .pe_req_ready_i  (pe_req_ready_o)
);

//--- vldu_top.f
src/vldu_pkg.sv
src/vinsn_queue.sv
src/beat_packer.sv
src/result_queue.sv
src/vldu_top.sv
tb/vldu_props.sv
tb/tb_vldu.sv
